//--- verilog/dtlb_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sv39 only, no ASIDs and no global pages
// Entry count must be a power of two
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package dtlb_pkg;

  // Default sizes, overridden from the top level
  localparam int unsigned DefaultEntries     = 8;
  localparam int unsigned DefaultMshrEntries = 4;

  // VPN seen as one word or as the three Sv39 level indices
  typedef union packed {
    logic [26:0]     flat;
    logic [2:0][8:0] lvl;
  } vpn_u;

  typedef logic [43:0] ppn_t;

  typedef enum logic [1:0] {KibiPage, MebiPage, GibiPage} page_type_e;
  typedef enum logic [1:0] {U = 2'b00, S = 2'b01, M = 2'b11} priv_e;
  typedef enum logic [1:0] {NoFlush, FlushPage, FlushAll} flush_e;
  typedef enum logic {NoException, PageFault} exc_e;

  // PTE bits that matter for loads and stores
  typedef struct packed {
    logic user;
    logic read;
    logic write;
    logic dirty;
  } pte_perm_t;

  typedef struct packed {
    logic       valid;
    vpn_u       vpn;
    ppn_t       ppn;
    page_type_e page_type;
    pte_perm_t  perm;
  } dtlb_entry_t;

  // Page compare at the granularity of the page type
  // Lower level indices are don't care for large pages
  function automatic logic vpn_match(page_type_e pt, vpn_u a, vpn_u b);
    case (pt)
      GibiPage: return a.lvl[2] == b.lvl[2];
      MebiPage: return a.lvl[2:1] == b.lvl[2:1];
      default:  return a.flat == b.flat;
    endcase
  endfunction

endpackage

//--- verilog/dtlb_miss_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Arbiter to MSHR link, add and remove are
// never raised in the same cycle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

interface dtlb_miss_if #(
  parameter int unsigned MshrEntries = dtlb_pkg::DefaultMshrEntries
);
  logic                         add;
  logic                         remove;
  dtlb_pkg::vpn_u               cmp_vpn;
  dtlb_pkg::page_type_e         cmp_page_type;
  logic                         hit;
  logic [MshrEntries-1:0]       hit_vec;
  logic                         full;

  modport arbiter (output add, remove, cmp_vpn, cmp_page_type, input hit, full);
  // Per-entry hit vector is read back by the MSHR for removal
  modport mshr (input add, remove, cmp_vpn, cmp_page_type, output hit, hit_vec, full);
endinterface

//--- verilog/dtlb_plru.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Tree PLRU, Entries a power of two >= 2
// Invalid entries are always filled first
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module dtlb_plru #(
  parameter int unsigned Entries = dtlb_pkg::DefaultEntries
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic [Entries-1:0] valid_vec_i,
  input  logic [Entries-1:0] hit_vec_i,
  input  logic               access_i,
  input  logic               fill_i,
  output logic [Entries-1:0] victim_vec_o
);
  localparam int unsigned LogN = $clog2(Entries);

  // Node n has children 2n+1 and 2n+2, bit set means victim on the right
  logic [Entries-2:0] tree_q, tree_d;
  logic [Entries-1:0] tree_vec, free_vec, used_vec;

  // Walk the tree from the root to a leaf
  always_comb begin
    int unsigned node;
    node     = 0;
    tree_vec = '0;
    for (int l = 0; l < LogN; l++) begin
      node = tree_q[node] ? 2 * node + 2 : 2 * node + 1;
    end
    tree_vec[node - (Entries - 1)] = 1'b1;
  end

  // Lowest invalid entry
  always_comb begin
    logic found;
    found    = 1'b0;
    free_vec = '0;
    for (int k = 0; k < Entries; k++) begin
      if (!valid_vec_i[k] && !found) begin
        free_vec[k] = 1'b1;
        found       = 1'b1;
      end
    end
  end

  assign victim_vec_o = (&valid_vec_i) ? tree_vec : free_vec;

  // Entry touched this cycle, a counted hit or the filled victim
  assign used_vec = access_i ? hit_vec_i : (fill_i ? victim_vec_o : '0);

  // Point every node on the path away from the used leaf
  always_comb begin
    tree_d = tree_q;
    for (int k = 0; k < Entries; k++) begin
      if (used_vec[k]) begin
        for (int l = 0; l < LogN; l++) begin
          tree_d[(1 << l) - 1 + (k >> (LogN - l))] = ((k >> (LogN - l - 1)) & 1) == 0;
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tree_q <= '0;
    end else if (access_i || fill_i) begin
      tree_q <= tree_d;
    end
  end

endmodule

//--- verilog/dtlb_entry_array.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fully associative, at most one entry is
// expected to match a request VPN
// Flush wins over fill on the same entry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module dtlb_entry_array #(
  parameter int unsigned Entries = dtlb_pkg::DefaultEntries
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 lookup_i,
  input  logic                 fill_i,
  input  dtlb_pkg::flush_e     flush_i,
  input  dtlb_pkg::vpn_u       flush_vpn_i,
  input  dtlb_pkg::vpn_u       req_vpn_i,
  input  logic                 req_store_i,
  input  dtlb_pkg::priv_e      priv_i,
  input  logic                 sum_i,
  input  dtlb_pkg::vpn_u       fill_vpn_i,
  input  dtlb_pkg::ppn_t       fill_ppn_i,
  input  dtlb_pkg::page_type_e fill_type_i,
  input  dtlb_pkg::pte_perm_t  fill_perm_i,
  output logic                 hit_o,
  output dtlb_pkg::ppn_t       ppn_o,
  output dtlb_pkg::exc_e       exc_o
);
  dtlb_pkg::dtlb_entry_t entry_q [Entries];

  logic [Entries-1:0] valid_vec, hit_vec, flush_vec, victim_vec;
  logic               fault;
  logic               access;

  // Compare all entries at once, each at its own page granularity
  always_comb begin
    hit_vec = '0;
    ppn_o   = '0;
    fault   = 1'b0;
    for (int k = 0; k < Entries; k++) begin
      valid_vec[k] = entry_q[k].valid;
      if (lookup_i && entry_q[k].valid &&
          dtlb_pkg::vpn_match(entry_q[k].page_type, entry_q[k].vpn, req_vpn_i)) begin
        hit_vec[k] = 1'b1;
        ppn_o      = entry_q[k].ppn;
        // Not readable, or store to a read-only or clean page
        fault = !entry_q[k].perm.read ||
                (req_store_i && (!entry_q[k].perm.write || !entry_q[k].perm.dirty));
        // User page from S mode needs SUM
        if (entry_q[k].perm.user && priv_i == dtlb_pkg::S && !sum_i) fault = 1'b1;
        // Supervisor page is off limits to U mode
        if (!entry_q[k].perm.user && priv_i == dtlb_pkg::U) fault = 1'b1;
      end
    end
  end

  assign hit_o  = |hit_vec;
  assign exc_o  = fault ? dtlb_pkg::PageFault : dtlb_pkg::NoException;
  // Faulting hits do not count as a use
  assign access = hit_o && !fault;

  // Entries hit by the current flush
  always_comb begin
    for (int k = 0; k < Entries; k++) begin
      case (flush_i)
        dtlb_pkg::FlushAll:  flush_vec[k] = 1'b1;
        dtlb_pkg::FlushPage: flush_vec[k] = dtlb_pkg::vpn_match(entry_q[k].page_type,
                                                                entry_q[k].vpn, flush_vpn_i);
        default:             flush_vec[k] = 1'b0;
      endcase
    end
  end

  dtlb_plru #(
    .Entries(Entries)
  ) plru_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .valid_vec_i  (valid_vec),
    .hit_vec_i    (hit_vec),
    .access_i     (access),
    .fill_i       (fill_i),
    .victim_vec_o (victim_vec)
  );

  for (genvar k = 0; k < Entries; k++) begin : g_entry
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        entry_q[k] <= '0;
      end else if (flush_vec[k]) begin
        entry_q[k].valid <= 1'b0;
      end else if (fill_i && victim_vec[k]) begin
        entry_q[k].valid     <= 1'b1;
        entry_q[k].vpn       <= fill_vpn_i;
        entry_q[k].ppn       <= fill_ppn_i;
        entry_q[k].page_type <= fill_type_i;
        entry_q[k].perm      <= fill_perm_i;
      end
    end
  end

endmodule

//--- verilog/dtlb_mshr.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// One L2 request per entry, an entry stays
// waiting until its answer removes it
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module dtlb_mshr #(
  parameter int unsigned MshrEntries = dtlb_pkg::DefaultMshrEntries
) (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           l2_req_ready_i,
  output logic           l2_req_valid_o,
  output dtlb_pkg::vpn_u l2_req_vpn_o,
  dtlb_miss_if.mshr      miss
);
  dtlb_pkg::vpn_u vpn_q [MshrEntries];

  logic [MshrEntries-1:0] valid_q, wait_q;
  logic [MshrEntries-1:0] free_sel, req_sel;

  // Compare at the granularity asked for by the arbiter
  always_comb begin
    for (int k = 0; k < MshrEntries; k++) begin
      miss.hit_vec[k] = valid_q[k] &&
                        dtlb_pkg::vpn_match(miss.cmp_page_type, vpn_q[k], miss.cmp_vpn);
    end
  end

  assign miss.hit  = |miss.hit_vec;
  assign miss.full = &valid_q;

  // Lowest free slot and lowest entry still to be sent to the L2
  always_comb begin
    free_sel     = '0;
    req_sel      = '0;
    l2_req_vpn_o = '0;
    for (int k = MshrEntries - 1; k >= 0; k--) begin
      if (!valid_q[k]) begin
        free_sel    = '0;
        free_sel[k] = 1'b1;
      end else if (!wait_q[k]) begin
        req_sel      = '0;
        req_sel[k]   = 1'b1;
        l2_req_vpn_o = vpn_q[k];
      end
    end
  end

  assign l2_req_valid_o = |req_sel;

  for (genvar k = 0; k < MshrEntries; k++) begin : g_slot
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        valid_q[k] <= 1'b0;
        wait_q[k]  <= 1'b0;
      end else if (miss.remove && miss.hit_vec[k]) begin
        valid_q[k] <= 1'b0;
        wait_q[k]  <= 1'b0;
      end else if (l2_req_ready_i && req_sel[k]) begin
        wait_q[k] <= 1'b1;
      end else if (miss.add && free_sel[k]) begin
        valid_q[k] <= 1'b1;
        wait_q[k]  <= 1'b0;
      end
    end

    // During an add the compare VPN is the request VPN
    always_ff @(posedge clk_i) begin
      if (miss.add && free_sel[k]) vpn_q[k] <= miss.cmp_vpn;
    end
  end

endmodule

//--- verilog/dtlb_arbiter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fixed priority: flush, L2 answer, LSQ
// L2 answers with no MSHR match are dropped
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module dtlb_arbiter (
  input  dtlb_pkg::flush_e     flush_i,
  input  logic                 req_valid_i,
  input  dtlb_pkg::vpn_u       req_vpn_i,
  input  logic                 l2_ans_valid_i,
  input  dtlb_pkg::vpn_u       l2_ans_vpn_i,
  input  dtlb_pkg::page_type_e l2_ans_type_i,
  input  dtlb_pkg::ppn_t       l2_ans_ppn_i,
  input  dtlb_pkg::exc_e       l2_ans_exc_i,
  input  logic                 tlb_hit_i,
  input  dtlb_pkg::ppn_t       tlb_ppn_i,
  input  dtlb_pkg::exc_e       tlb_exc_i,
  output logic                 lookup_o,
  output logic                 fill_o,
  output dtlb_pkg::flush_e     flush_o,
  output logic                 req_ready_o,
  output logic                 ans_valid_o,
  output dtlb_pkg::ppn_t       ans_ppn_o,
  output dtlb_pkg::exc_e       ans_exc_o,
  output logic                 wup_valid_o,
  output dtlb_pkg::vpn_u       wup_vpn_o,
  dtlb_miss_if.arbiter         miss
);
  logic serve_flush, serve_ans, ans_match;

  assign serve_flush = flush_i != dtlb_pkg::NoFlush;
  assign serve_ans   = !serve_flush && l2_ans_valid_i;
  assign req_ready_o = !serve_flush && !l2_ans_valid_i && !miss.full;
  assign lookup_o    = req_ready_o && req_valid_i;
  assign flush_o     = flush_i;

  // MSHR compare uses the answer's page size, LSQ requests are exact
  assign miss.cmp_vpn       = serve_ans ? l2_ans_vpn_i : req_vpn_i;
  assign miss.cmp_page_type = serve_ans ? l2_ans_type_i : dtlb_pkg::KibiPage;

  // Merge a miss into an outstanding entry when possible
  assign miss.add    = lookup_o && !tlb_hit_i && !miss.hit;
  assign ans_match   = serve_ans && miss.hit;
  assign miss.remove = ans_match;
  // Faulting translations are not cached
  assign fill_o      = ans_match && l2_ans_exc_i == dtlb_pkg::NoException;

  assign wup_valid_o = ans_match;
  assign wup_vpn_o   = l2_ans_vpn_i;
  assign ans_valid_o = ans_match || (lookup_o && tlb_hit_i);
  assign ans_ppn_o   = serve_ans ? l2_ans_ppn_i : tlb_ppn_i;
  assign ans_exc_o   = serve_ans ? l2_ans_exc_i : tlb_exc_i;

endmodule

//--- verilog/dtlb_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// L2 answer port has no ready, answers are
// always taken. Entries a power of two
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module dtlb_top #(
  parameter int unsigned Entries     = dtlb_pkg::DefaultEntries,
  parameter int unsigned MshrEntries = dtlb_pkg::DefaultMshrEntries
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 sum_i,
  input  dtlb_pkg::priv_e      priv_i,
  input  dtlb_pkg::flush_e     flush_i,
  input  dtlb_pkg::vpn_u       flush_vpn_i,
  input  logic                 req_valid_i,
  input  dtlb_pkg::vpn_u       req_vpn_i,
  input  logic                 req_store_i,
  output logic                 req_ready_o,
  output logic                 ans_valid_o,
  output dtlb_pkg::ppn_t       ans_ppn_o,
  output dtlb_pkg::exc_e       ans_exc_o,
  output logic                 wup_valid_o,
  output dtlb_pkg::vpn_u       wup_vpn_o,
  output logic                 l2_req_valid_o,
  output dtlb_pkg::vpn_u       l2_req_vpn_o,
  input  logic                 l2_req_ready_i,
  input  logic                 l2_ans_valid_i,
  input  dtlb_pkg::vpn_u       l2_ans_vpn_i,
  input  dtlb_pkg::ppn_t       l2_ans_ppn_i,
  input  dtlb_pkg::page_type_e l2_ans_type_i,
  input  dtlb_pkg::pte_perm_t  l2_ans_perm_i,
  input  dtlb_pkg::exc_e       l2_ans_exc_i
);
  logic             lookup, fill, tlb_hit;
  dtlb_pkg::flush_e flush;
  dtlb_pkg::ppn_t   tlb_ppn;
  dtlb_pkg::exc_e   tlb_exc;

  dtlb_miss_if #(.MshrEntries(MshrEntries)) miss_if ();

  dtlb_arbiter arbiter_i (
    .flush_i        (flush_i),
    .req_valid_i    (req_valid_i),
    .req_vpn_i      (req_vpn_i),
    .l2_ans_valid_i (l2_ans_valid_i),
    .l2_ans_vpn_i   (l2_ans_vpn_i),
    .l2_ans_type_i  (l2_ans_type_i),
    .l2_ans_ppn_i   (l2_ans_ppn_i),
    .l2_ans_exc_i   (l2_ans_exc_i),
    .tlb_hit_i      (tlb_hit),
    .tlb_ppn_i      (tlb_ppn),
    .tlb_exc_i      (tlb_exc),
    .lookup_o       (lookup),
    .fill_o         (fill),
    .flush_o        (flush),
    .req_ready_o    (req_ready_o),
    .ans_valid_o    (ans_valid_o),
    .ans_ppn_o      (ans_ppn_o),
    .ans_exc_o      (ans_exc_o),
    .wup_valid_o    (wup_valid_o),
    .wup_vpn_o      (wup_vpn_o),
    .miss           (miss_if.arbiter)
  );

  // Fill data comes straight from the L2 answer
  dtlb_entry_array #(
    .Entries(Entries)
  ) array_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .lookup_i    (lookup),
    .fill_i      (fill),
    .flush_i     (flush),
    .flush_vpn_i (flush_vpn_i),
    .req_vpn_i   (req_vpn_i),
    .req_store_i (req_store_i),
    .priv_i      (priv_i),
    .sum_i       (sum_i),
    .fill_vpn_i  (l2_ans_vpn_i),
    .fill_ppn_i  (l2_ans_ppn_i),
    .fill_type_i (l2_ans_type_i),
    .fill_perm_i (l2_ans_perm_i),
    .hit_o       (tlb_hit),
    .ppn_o       (tlb_ppn),
    .exc_o       (tlb_exc)
  );

  dtlb_mshr #(
    .MshrEntries(MshrEntries)
  ) mshr_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .l2_req_ready_i (l2_req_ready_i),
    .l2_req_valid_o (l2_req_valid_o),
    .l2_req_vpn_o   (l2_req_vpn_o),
    .miss           (miss_if.mshr)
  );

endmodule

//--- dv/tb_dtlb_model.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Included inside tb_dtlb
// Pages in the model never overlap and
// there is no capacity limit
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef TB_DTLB_MODEL_SVH
`define TB_DTLB_MODEL_SVH

// Installed pages, and misses that the MSHR still holds
dtlb_pkg::dtlb_entry_t page_q [$];
dtlb_pkg::vpn_u        pend_q [$];
// L2 requests expected on the port, in order
dtlb_pkg::vpn_u        l2_exp_q [$];

task automatic stop_run(string why);
  $display("%s", why);
  $display("Test failed");
  $fatal(1, "stopping at first error");
endtask

// A page covers an address when the levels above its size agree
function automatic logic covers(dtlb_pkg::page_type_e pt, dtlb_pkg::vpn_u page,
                                dtlb_pkg::vpn_u addr);
  int unsigned low;
  low = (pt == dtlb_pkg::GibiPage) ? 18 : ((pt == dtlb_pkg::MebiPage) ? 9 : 0);
  return (page.flat >> low) == (addr.flat >> low);
endfunction

// Expected hit, ppn and exception of a load or store
function automatic logic ref_lookup(input dtlb_pkg::vpn_u vpn, input logic store,
                                    input dtlb_pkg::priv_e priv, input logic sum,
                                    output dtlb_pkg::ppn_t ppn, output dtlb_pkg::exc_e exc);
  logic bad;
  ppn = '0;
  exc = dtlb_pkg::NoException;
  foreach (page_q[i]) begin
    if (covers(page_q[i].page_type, page_q[i].vpn, vpn)) begin
      bad = !page_q[i].perm.read;
      // Stores need a writable and dirty page
      if (store && !(page_q[i].perm.write && page_q[i].perm.dirty)) bad = 1'b1;
      if (priv == dtlb_pkg::U && !page_q[i].perm.user) bad = 1'b1;
      if (priv == dtlb_pkg::S && page_q[i].perm.user && !sum) bad = 1'b1;
      ppn = page_q[i].ppn;
      exc = bad ? dtlb_pkg::PageFault : dtlb_pkg::NoException;
      return 1'b1;
    end
  end
  return 1'b0;
endfunction

task automatic install_page(dtlb_pkg::vpn_u vpn, dtlb_pkg::ppn_t ppn,
                            dtlb_pkg::page_type_e pt, dtlb_pkg::pte_perm_t perm);
  dtlb_pkg::dtlb_entry_t e;
  // A refetched page replaces its old copy
  for (int i = page_q.size() - 1; i >= 0; i--) begin
    if (covers(page_q[i].page_type, page_q[i].vpn, vpn)) page_q.delete(i);
  end
  e.valid     = 1'b1;
  e.vpn       = vpn;
  e.ppn       = ppn;
  e.page_type = pt;
  e.perm      = perm;
  page_q.push_back(e);
endtask

// Page flush drops the pages that cover the address
task automatic flush_pages(dtlb_pkg::vpn_u vpn);
  for (int i = page_q.size() - 1; i >= 0; i--) begin
    if (covers(page_q[i].page_type, page_q[i].vpn, vpn)) page_q.delete(i);
  end
endtask

// An L2 answer releases every miss inside its page
task automatic drop_pending(dtlb_pkg::page_type_e pt, dtlb_pkg::vpn_u vpn);
  for (int i = pend_q.size() - 1; i >= 0; i--) begin
    if (covers(pt, pend_q[i], vpn)) pend_q.delete(i);
  end
  for (int i = l2_exp_q.size() - 1; i >= 0; i--) begin
    if (covers(pt, l2_exp_q[i], vpn)) l2_exp_q.delete(i);
  end
endtask

// New miss unless the same 4 KiB page is already outstanding
task automatic note_miss(dtlb_pkg::vpn_u vpn);
  foreach (pend_q[i]) begin
    if (pend_q[i].flat == vpn.flat) return;
  end
  pend_q.push_back(vpn);
  l2_exp_q.push_back(vpn);
endtask

task automatic check_ppn(string name, dtlb_pkg::ppn_t exp, dtlb_pkg::ppn_t act);
  if (exp !== act) begin
    stop_run($sformatf("FAILED at %0t: %s expected %h actual %h", $time, name, exp, act));
  end
endtask

task automatic check_exc(string name, dtlb_pkg::exc_e exp, dtlb_pkg::exc_e act);
  if (exp !== act) begin
    stop_run($sformatf("FAILED at %0t: %s expected %s actual %s",
                       $time, name, exp.name(), act.name()));
  end
endtask

task automatic check_vpn(string name, dtlb_pkg::vpn_u exp, dtlb_pkg::vpn_u act);
  if (exp.flat !== act.flat) begin
    stop_run($sformatf("FAILED at %0t: %s expected %h actual %h",
                       $time, name, exp.flat, act.flat));
  end
endtask

task automatic check_bit(string name, logic exp, logic act);
  if (exp !== act) begin
    stop_run($sformatf("FAILED at %0t: %s expected %b actual %b", $time, name, exp, act));
  end
endtask

task automatic check_count(string name, int exp, int act);
  if (exp != act) begin
    stop_run($sformatf("FAILED at %0t: %s expected %0d actual %0d", $time, name, exp, act));
  end
endtask

`endif

//--- dv/tb_dtlb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Inputs change 10 ns after the rising edge
// Outputs are checked at the falling edge
// The L2 is always ready
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module tb_dtlb;

  logic                 clk_i, rst_ni, sum_i, req_valid_i, req_store_i;
  logic                 req_ready_o, ans_valid_o, wup_valid_o, l2_req_valid_o;
  logic                 l2_req_ready_i, l2_ans_valid_i;
  dtlb_pkg::priv_e      priv_i;
  dtlb_pkg::flush_e     flush_i;
  dtlb_pkg::vpn_u       flush_vpn_i, req_vpn_i, wup_vpn_o, l2_req_vpn_o, l2_ans_vpn_i;
  dtlb_pkg::ppn_t       ans_ppn_o, l2_ans_ppn_i;
  dtlb_pkg::exc_e       ans_exc_o, l2_ans_exc_i;
  dtlb_pkg::page_type_e l2_ans_type_i;
  dtlb_pkg::pte_perm_t  l2_ans_perm_i;

  // Expected response of the cycle being driven
  logic                 exp_ans, exp_loose, exp_wup, loose_hits;
  dtlb_pkg::ppn_t       exp_ppn;
  dtlb_pkg::exc_e       exp_exc;
  dtlb_pkg::vpn_u       exp_wup_vpn, cur_vpn;
  int unsigned          hit_count, next_tag;

  localparam dtlb_pkg::pte_perm_t FullPerm = 4'b1111;

  `include "tb_dtlb_model.svh"

  dtlb_top #(.Entries(8), .MshrEntries(4)) dut_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // Overall limit on top of the per-wait timeouts
  initial begin
    #1ms;
    stop_run("Simulation ran past its time limit");
  end

  task automatic go_idle();
    req_valid_i    = 1'b0;
    req_store_i    = 1'b0;
    flush_i        = dtlb_pkg::NoFlush;
    l2_ans_valid_i = 1'b0;
    exp_ans        = 1'b0;
    exp_loose      = 1'b0;
    exp_wup        = 1'b0;
  endtask

  // One request cycle, then one idle cycle
  task automatic lookup_page(dtlb_pkg::vpn_u vpn, logic store, dtlb_pkg::priv_e priv,
                             logic sum);
    @(posedge clk_i);
    #10;
    req_valid_i = 1'b1;
    req_vpn_i   = vpn;
    req_store_i = store;
    priv_i      = priv;
    sum_i       = sum;
    cur_vpn     = vpn;
    exp_ans     = ref_lookup(vpn, store, priv, sum, exp_ppn, exp_exc);
    // Hit or miss is left to the checker after an eviction
    if (loose_hits) begin
      exp_loose = 1'b1;
      exp_ans   = 1'b0;
    end else if (!exp_ans) begin
      note_miss(vpn);
    end
    @(posedge clk_i);
    #10;
    go_idle();
  endtask

  task automatic answer_miss(dtlb_pkg::vpn_u vpn, dtlb_pkg::ppn_t ppn,
                             dtlb_pkg::page_type_e pt, dtlb_pkg::pte_perm_t perm,
                             dtlb_pkg::exc_e exc);
    @(posedge clk_i);
    #10;
    l2_ans_valid_i = 1'b1;
    l2_ans_vpn_i   = vpn;
    l2_ans_ppn_i   = ppn;
    l2_ans_type_i  = pt;
    l2_ans_perm_i  = perm;
    l2_ans_exc_i   = exc;
    foreach (pend_q[i]) begin
      if (covers(pt, pend_q[i], vpn)) exp_wup = 1'b1;
    end
    exp_ans     = exp_wup;
    exp_ppn     = ppn;
    exp_exc     = exc;
    exp_wup_vpn = vpn;
    if (exp_wup) begin
      drop_pending(pt, vpn);
      // Faulting answers are not cached
      if (exc == dtlb_pkg::NoException) install_page(vpn, ppn, pt, perm);
    end
    @(posedge clk_i);
    #10;
    go_idle();
  endtask

  task automatic flush_tlb(dtlb_pkg::flush_e kind, dtlb_pkg::vpn_u vpn);
    @(posedge clk_i);
    #10;
    flush_i     = kind;
    flush_vpn_i = vpn;
    if (kind == dtlb_pkg::FlushAll) page_q.delete();
    else flush_pages(vpn);
    @(posedge clk_i);
    #10;
    go_idle();
  endtask

  task automatic wait_l2_sent();
    int unsigned n;
    n = 0;
    while (l2_exp_q.size() != 0) begin
      if (n == 20) stop_run("Timeout waiting for the expected L2 requests");
      n++;
      @(posedge clk_i);
    end
  endtask

  // Answer every outstanding miss with a plain 4 KiB page
  task automatic drain_misses();
    wait_l2_sent();
    while (pend_q.size() != 0) begin
      answer_miss(pend_q[0], dtlb_pkg::ppn_t'({$urandom, $urandom}), dtlb_pkg::KibiPage,
                  FullPerm, dtlb_pkg::NoException);
    end
  endtask

  // Miss, L2 request, then an answer that installs the page
  task automatic fetch_page(dtlb_pkg::vpn_u vpn, dtlb_pkg::page_type_e pt,
                            dtlb_pkg::pte_perm_t perm);
    lookup_page(vpn, 1'b0, dtlb_pkg::S, 1'b1);
    wait_l2_sent();
    answer_miss(vpn, dtlb_pkg::ppn_t'({$urandom, $urandom}), pt, perm,
                dtlb_pkg::NoException);
  endtask

  // A distinct top level index keeps pages apart
  function automatic dtlb_pkg::vpn_u new_vpn();
    dtlb_pkg::vpn_u v;
    v.flat = {9'(next_tag), 18'($urandom)};
    next_tag++;
    return v;
  endfunction

  // Compare at the falling edge of every cycle
  always @(negedge clk_i) begin
    if (rst_ni) begin
      // A driven request must be taken in the same cycle
      if (req_valid_i) check_bit("req_ready_o", 1'b1, req_ready_o);
      if (exp_loose) begin
        if (ans_valid_o) begin
          check_ppn("ans_ppn_o", exp_ppn, ans_ppn_o);
          check_exc("ans_exc_o", exp_exc, ans_exc_o);
        end else begin
          note_miss(cur_vpn);
        end
      end else begin
        check_bit("ans_valid_o", exp_ans, ans_valid_o);
        if (exp_ans) begin
          check_ppn("ans_ppn_o", exp_ppn, ans_ppn_o);
          check_exc("ans_exc_o", exp_exc, ans_exc_o);
        end
      end
      if (ans_valid_o) hit_count++;
      check_bit("wup_valid_o", exp_wup, wup_valid_o);
      if (exp_wup) check_vpn("wup_vpn_o", exp_wup_vpn, wup_vpn_o);
      if (l2_req_valid_o) begin
        if (l2_exp_q.size() == 0) begin
          stop_run($sformatf("Unexpected L2 request for VPN %h", l2_req_vpn_o.flat));
        end
        check_vpn("l2_req_vpn_o", l2_exp_q[0], l2_req_vpn_o);
        if (l2_req_ready_i) void'(l2_exp_q.pop_front());
      end
    end
  end

  initial begin
    dtlb_pkg::vpn_u      va, vin;
    dtlb_pkg::vpn_u      pages [9];
    dtlb_pkg::priv_e     pv;
    dtlb_pkg::page_type_e pt;
    void'($urandom(32'h6245_01ba));
    hit_count      = 0;
    next_tag       = 1;
    loose_hits     = 1'b0;
    rst_ni         = 1'b0;
    sum_i          = 1'b1;
    priv_i         = dtlb_pkg::S;
    flush_vpn_i    = '0;
    req_vpn_i      = '0;
    l2_req_ready_i = 1'b1;
    l2_ans_vpn_i   = '0;
    l2_ans_ppn_i   = '0;
    l2_ans_type_i  = dtlb_pkg::KibiPage;
    l2_ans_perm_i  = '0;
    l2_ans_exc_i   = dtlb_pkg::NoException;
    go_idle();
    repeat (3) @(posedge clk_i);
    #10;
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_bit("req_ready_o", 1'b1, req_ready_o);
    check_bit("l2_req_valid_o", 1'b0, l2_req_valid_o);

    // One L2 request per page, a repeated miss merges
    va = new_vpn();
    lookup_page(va, 1'b0, dtlb_pkg::S, 1'b1);
    lookup_page(va, 1'b0, dtlb_pkg::S, 1'b1);
    wait_l2_sent();
    lookup_page(va, 1'b1, dtlb_pkg::S, 1'b1);
    repeat (5) @(posedge clk_i);

    // Fill and hit for each page size, inside the page for large ones
    answer_miss(va, dtlb_pkg::ppn_t'({$urandom, $urandom}), dtlb_pkg::KibiPage, FullPerm,
                dtlb_pkg::NoException);
    lookup_page(va, 1'b0, dtlb_pkg::S, 1'b1);
    for (int k = 1; k <= 2; k++) begin
      pt = (k == 1) ? dtlb_pkg::MebiPage : dtlb_pkg::GibiPage;
      va = new_vpn();
      fetch_page(va, pt, FullPerm);
      vin = va;
      if (k == 1) vin.flat[8:0] = 9'($urandom);
      else vin.flat[17:0] = 18'($urandom);
      lookup_page(vin, 1'b1, dtlb_pkg::S, 1'b1);
    end
    // A faulting answer installs nothing
    va = new_vpn();
    lookup_page(va, 1'b0, dtlb_pkg::S, 1'b1);
    wait_l2_sent();
    answer_miss(va, dtlb_pkg::ppn_t'($urandom), dtlb_pkg::KibiPage, FullPerm,
                dtlb_pkg::PageFault);
    lookup_page(va, 1'b0, dtlb_pkg::S, 1'b1);
    drain_misses();
    flush_tlb(dtlb_pkg::FlushAll, '0);

    // Random permissions against store, mode and SUM
    for (int k = 0; k < 12; k++) begin
      va = new_vpn();
      fetch_page(va, dtlb_pkg::KibiPage, dtlb_pkg::pte_perm_t'($urandom));
      for (int j = 0; j < 4; j++) begin
        case ($urandom_range(2))
          0:       pv = dtlb_pkg::U;
          1:       pv = dtlb_pkg::S;
          default: pv = dtlb_pkg::M;
        endcase
        lookup_page(va, 1'($urandom), pv, 1'($urandom));
      end
      flush_tlb(dtlb_pkg::FlushPage, va);
    end

    // Page flush inside a 2 MiB and a 1 GiB page, then a full flush
    for (int k = 0; k < 4; k++) begin
      pages[k] = new_vpn();
      pt = (k == 1) ? dtlb_pkg::MebiPage :
           ((k == 2) ? dtlb_pkg::GibiPage : dtlb_pkg::KibiPage);
      fetch_page(pages[k], pt, FullPerm);
    end
    vin = pages[1];
    vin.flat[8:0] = 9'($urandom);
    flush_tlb(dtlb_pkg::FlushPage, vin);
    vin = pages[2];
    vin.flat[17:0] = 18'($urandom);
    flush_tlb(dtlb_pkg::FlushPage, vin);
    for (int k = 0; k < 4; k++) lookup_page(pages[k], 1'b0, dtlb_pkg::S, 1'b1);
    drain_misses();
    flush_tlb(dtlb_pkg::FlushAll, '0);
    for (int k = 0; k < 4; k++) lookup_page(pages[k], 1'b0, dtlb_pkg::S, 1'b1);
    drain_misses();
    flush_tlb(dtlb_pkg::FlushAll, '0);

    // Four sent misses fill the MSHR
    for (int k = 0; k < 4; k++) lookup_page(new_vpn(), 1'b0, dtlb_pkg::S, 1'b1);
    wait_l2_sent();
    @(negedge clk_i);
    check_bit("req_ready_o", 1'b0, req_ready_o);
    answer_miss(pend_q[0], dtlb_pkg::ppn_t'($urandom), dtlb_pkg::KibiPage, FullPerm,
                dtlb_pkg::NoException);
    @(negedge clk_i);
    check_bit("req_ready_o", 1'b1, req_ready_o);
    drain_misses();
    flush_tlb(dtlb_pkg::FlushAll, '0);

    // Nine pages into eight entries leave eight hits
    for (int k = 0; k < 9; k++) begin
      pages[k] = new_vpn();
      fetch_page(pages[k], dtlb_pkg::KibiPage, FullPerm);
    end
    loose_hits = 1'b1;
    hit_count  = 0;
    for (int k = 0; k < 9; k++) lookup_page(pages[k], 1'b0, dtlb_pkg::S, 1'b1);
    check_count("hit count", 8, hit_count);
    loose_hits = 1'b0;
    drain_misses();
    flush_tlb(dtlb_pkg::FlushAll, '0);

    repeat (3) @(posedge clk_i);
    $display("Test passed");
    $finish;
  end

endmodule

//--- compile.f
+incdir+dv
verilog/dtlb_pkg.sv
verilog/dtlb_miss_if.sv
verilog/dtlb_plru.sv
verilog/dtlb_entry_array.sv
verilog/dtlb_mshr.sv
verilog/dtlb_arbiter.sv
verilog/dtlb_top.sv
dv/tb_dtlb.sv

//--- Bender.yml
package:
  name: dtlb

sources:
  - verilog/dtlb_pkg.sv
  - verilog/dtlb_miss_if.sv
  - verilog/dtlb_plru.sv
  - verilog/dtlb_entry_array.sv
  - verilog/dtlb_mshr.sv
  - verilog/dtlb_arbiter.sv
  - verilog/dtlb_top.sv
  - target: simulation
    include_dirs:
      - dv
    files:
      - dv/tb_dtlb.sv
